// File: design/axi_ram_pkg.sv
package axi_ram_pkg;

    // Bus geometry
    localparam int AXI_DATA_WIDTH = 128;
    localparam int AXI_ADDR_WIDTH = 32;
    localparam int AXI_ID_WIDTH   = 6;
    localparam int AXI_STRB_WIDTH = AXI_DATA_WIDTH / 8;

    // Byte address bits inside one bus word
    localparam int WORD_LSB       = $clog2(AXI_STRB_WIDTH);
    localparam int RAM_ADDR_WIDTH = AXI_ADDR_WIDTH - WORD_LSB;

    localparam logic [1:0] RESP_OKAY = 2'b00;

    typedef logic [AXI_DATA_WIDTH-1:0] axi_data_t;
    typedef logic [AXI_STRB_WIDTH-1:0] axi_strb_t;
    typedef logic [AXI_ID_WIDTH-1:0]   axi_id_t;
    typedef logic [RAM_ADDR_WIDTH-1:0] ram_addr_t;

    typedef enum logic [1:0] {
        FIXED = 2'b00,
        INCR  = 2'b01,
        WRAP  = 2'b10
    } burst_t;

    // Shared by AR and AW
    typedef struct packed {
        axi_id_t                   id;
        logic [AXI_ADDR_WIDTH-1:0] addr;
        logic [7:0]                len;
        logic [2:0]                size;
        burst_t                    burst;
    } axi_ax_t;

    typedef struct packed {
        axi_id_t    id;
        axi_data_t  data;
        logic [1:0] resp;
        logic       last;
    } axi_r_t;

    typedef struct packed {
        axi_data_t data;
        axi_strb_t strb;
        logic      last;
    } axi_w_t;

    typedef struct packed {
        axi_id_t    id;
        logic [1:0] resp;
    } axi_b_t;

endpackage

// File: design/axi_skid_buffer.sv
`timescale 1ns/1ps

module axi_skid_buffer #(
    parameter type T_PAYLOAD = logic
) (
    input  logic     clk,
    input  logic     i_rst_n,
    input  T_PAYLOAD i_data,
    input  logic     i_valid,
    output logic     o_ready,
    output T_PAYLOAD o_data,
    output logic     o_valid,
    input  logic     i_ready
);

    T_PAYLOAD   mem [2];
    logic [1:0] count;
    logic       wr_ptr;
    logic       rd_ptr;
    logic       push;
    logic       pop;

    assign push = i_valid && o_ready;
    assign pop  = o_valid && i_ready;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            count  <= 2'd0;
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= ~wr_ptr;
            end
            if (pop) begin
                rd_ptr <= ~rd_ptr;
            end
            case ({push, pop})
                2'b10:   count <= count + 2'd1;
                2'b01:   count <= count - 2'd1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= i_data;
        end
    end

    // Ready from fill level only, no path from i_ready
    assign o_ready = (count != 2'd2);
    assign o_valid = (count != 2'd0);
    assign o_data  = mem[rd_ptr];

endmodule

// File: design/burst_addr_gen.sv
`timescale 1ns/1ps

module burst_addr_gen (
    input  logic                   clk,
    input  logic                   i_rst_n,
    input  logic                   i_start,
    input  axi_ram_pkg::axi_ax_t   i_req,
    input  logic                   i_step,
    output axi_ram_pkg::ram_addr_t o_addr,
    output logic                   o_last,
    output logic                   o_busy
);
    import axi_ram_pkg::*;

    ram_addr_t  addr;
    burst_t     burst;
    logic [7:0] beats_left;
    logic       busy;
    logic       advance;

    assign advance = i_step && busy;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            busy       <= 1'b0;
            beats_left <= 8'd0;
        end else if (i_start) begin
            busy       <= 1'b1;
            beats_left <= i_req.len;
        end else if (advance) begin
            if (beats_left == 8'd0) begin
                busy <= 1'b0;
            end else begin
                beats_left <= beats_left - 8'd1;
            end
        end
    end

    // FIXED bursts hold the word address
    // WRAP walks like INCR
    always_ff @(posedge clk) begin
        if (i_start) begin
            addr  <= i_req.addr[AXI_ADDR_WIDTH-1:WORD_LSB];
            burst <= i_req.burst;
        end else if (advance && burst != FIXED) begin
            addr <= addr + ram_addr_t'(1);
        end
    end

    assign o_addr = addr;
    assign o_last = busy && (beats_left == 8'd0);
    assign o_busy = busy;

endmodule

// File: design/axi_read_to_ram.sv
`timescale 1ns/1ps

module axi_read_to_ram #(
    parameter bit OPT_LOWPOWER = 1'b0
) (
    input  logic                   clk,
    input  logic                   i_rst_n,
    input  axi_ram_pkg::axi_ax_t   i_ar,
    input  logic                   i_ar_valid,
    output logic                   o_ar_ready,
    output axi_ram_pkg::axi_r_t    o_r,
    output logic                   o_r_valid,
    input  logic                   i_r_ready,
    output logic                   o_rd,
    output axi_ram_pkg::ram_addr_t o_raddr,
    input  axi_ram_pkg::axi_data_t i_rdata
);
    import axi_ram_pkg::*;

    localparam int SKID_DEPTH = 2;

    logic       ar_ready;
    logic       ar_fire;
    axi_id_t    burst_id;
    ram_addr_t  gen_addr;
    logic       gen_last;
    logic       gen_busy;
    logic       rd_issue;
    logic       r_fire;
    logic [1:0] credit_used;
    logic       rd_q;
    axi_id_t    id_q;
    logic       last_q;
    axi_r_t     r_beat;

    assign ar_fire    = i_ar_valid && ar_ready;
    assign o_ar_ready = ar_ready;
    assign r_fire     = o_r_valid && i_r_ready;

    // Beats in flight plus beats held must fit the skid buffer
    assign rd_issue = gen_busy && (credit_used < 2'(SKID_DEPTH));

    burst_addr_gen u_addr_gen (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_start (ar_fire),
        .i_req   (i_ar),
        .i_step  (rd_issue),
        .o_addr  (gen_addr),
        .o_last  (gen_last),
        .o_busy  (gen_busy)
    );

    // Reopen AR once the last read of the burst is out
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            ar_ready <= 1'b0;
        end else if (ar_fire) begin
            ar_ready <= 1'b0;
        end else if (!gen_busy || (rd_issue && gen_last)) begin
            ar_ready <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (ar_fire) begin
            burst_id <= i_ar.id;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            credit_used <= 2'd0;
        end else begin
            case ({rd_issue, r_fire})
                2'b10:   credit_used <= credit_used + 2'd1;
                2'b01:   credit_used <= credit_used - 2'd1;
                default: credit_used <= credit_used;
            endcase
        end
    end

    // ID and last ride along with the one-cycle RAM latency
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            rd_q <= 1'b0;
        end else begin
            rd_q <= rd_issue;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_issue) begin
            id_q   <= burst_id;
            last_q <= gen_last;
        end
    end

    always_comb begin
        r_beat.id   = id_q;
        r_beat.data = i_rdata;
        r_beat.resp = RESP_OKAY;
        r_beat.last = last_q;
    end

    axi_skid_buffer #(
        .T_PAYLOAD (axi_r_t)
    ) u_r_skid (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_data  (r_beat),
        .i_valid (rd_q),
        .o_ready (),
        .o_data  (o_r),
        .o_valid (o_r_valid),
        .i_ready (i_r_ready)
    );

    assign o_rd    = rd_issue;
    assign o_raddr = (OPT_LOWPOWER && !rd_issue) ? '0 : gen_addr;

endmodule

// File: design/axi_write_to_ram.sv
`timescale 1ns/1ps

module axi_write_to_ram #(
    parameter bit OPT_LOWPOWER = 1'b0
) (
    input  logic                   clk,
    input  logic                   i_rst_n,
    input  axi_ram_pkg::axi_ax_t   i_aw,
    input  logic                   i_aw_valid,
    output logic                   o_aw_ready,
    input  axi_ram_pkg::axi_w_t    i_w,
    input  logic                   i_w_valid,
    output logic                   o_w_ready,
    output axi_ram_pkg::axi_b_t    o_b,
    output logic                   o_b_valid,
    input  logic                   i_b_ready,
    output logic                   o_we,
    output axi_ram_pkg::ram_addr_t o_waddr,
    output axi_ram_pkg::axi_data_t o_wdata,
    output axi_ram_pkg::axi_strb_t o_wstrb
);
    import axi_ram_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_DATA,
        S_RESP
    } state_t;

    state_t    state;
    logic      aw_ready;
    logic      aw_fire;
    logic      aw_skid_ready;
    logic      aw_skid_valid;
    axi_ax_t   aw_req;
    logic      aw_start;
    logic      w_open;
    logic      w_fire;
    logic      w_skid_ready;
    logic      w_skid_valid;
    axi_w_t    w_beat;
    logic      w_pop;
    ram_addr_t gen_addr;
    logic      gen_last;
    logic      gen_busy;
    axi_id_t   b_id;
    logic      b_fire;

    assign o_aw_ready = aw_ready && aw_skid_ready;
    assign aw_fire    = i_aw_valid && o_aw_ready;

    // W only opens after its AW has been taken
    assign o_w_ready = w_open && w_skid_ready;
    assign w_fire    = i_w_valid && o_w_ready;

    assign aw_start = aw_skid_valid && (state == S_IDLE);
    assign w_pop    = w_skid_valid && gen_busy;
    assign b_fire   = o_b_valid && i_b_ready;

    axi_skid_buffer #(
        .T_PAYLOAD (axi_ax_t)
    ) u_aw_skid (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_data  (i_aw),
        .i_valid (i_aw_valid && aw_ready),
        .o_ready (aw_skid_ready),
        .o_data  (aw_req),
        .o_valid (aw_skid_valid),
        .i_ready (state == S_IDLE)
    );

    axi_skid_buffer #(
        .T_PAYLOAD (axi_w_t)
    ) u_w_skid (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_data  (i_w),
        .i_valid (i_w_valid && w_open),
        .o_ready (w_skid_ready),
        .o_data  (w_beat),
        .o_valid (w_skid_valid),
        .i_ready (gen_busy)
    );

    burst_addr_gen u_addr_gen (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_start (aw_start),
        .i_req   (aw_req),
        .i_step  (w_pop),
        .o_addr  (gen_addr),
        .o_last  (gen_last),
        .o_busy  (gen_busy)
    );

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    if (aw_start) begin
                        state <= S_DATA;
                    end
                end
                S_DATA: begin
                    if (w_pop && gen_last) begin
                        state <= S_RESP;
                    end
                end
                S_RESP: begin
                    if (b_fire) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // One burst at a time, AW held off until B is taken
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            aw_ready <= 1'b0;
        end else if (aw_fire) begin
            aw_ready <= 1'b0;
        end else if (b_fire || (state == S_IDLE && !aw_skid_valid)) begin
            aw_ready <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            w_open <= 1'b0;
        end else if (aw_fire) begin
            w_open <= 1'b1;
        end else if (w_fire && i_w.last) begin
            w_open <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (aw_start) begin
            b_id <= aw_req.id;
        end
    end

    always_comb begin
        o_b.id   = b_id;
        o_b.resp = RESP_OKAY;
    end

    assign o_b_valid = (state == S_RESP);

    assign o_we    = w_pop;
    assign o_waddr = (OPT_LOWPOWER && !w_pop) ? '0 : gen_addr;
    assign o_wdata = (OPT_LOWPOWER && !w_pop) ? '0 : w_beat.data;
    assign o_wstrb = (OPT_LOWPOWER && !w_pop) ? '0 : w_beat.strb;

endmodule

// File: design/axi_ram_bridge_top.sv
`timescale 1ns/1ps

module axi_ram_bridge_top #(
    parameter bit OPT_LOWPOWER = 1'b0
) (
    input  logic                   clk,
    input  logic                   i_rst_n,
    // Pixel read port
    input  axi_ram_pkg::axi_ax_t   i_pixel_ar,
    input  logic                   i_pixel_ar_valid,
    output logic                   o_pixel_ar_ready,
    output axi_ram_pkg::axi_r_t    o_pixel_r,
    output logic                   o_pixel_r_valid,
    input  logic                   i_pixel_r_ready,
    output logic                   o_pixel_rd,
    output axi_ram_pkg::ram_addr_t o_pixel_raddr,
    input  axi_ram_pkg::axi_data_t i_pixel_rdata,
    // Weights read port
    input  axi_ram_pkg::axi_ax_t   i_weights_ar,
    input  logic                   i_weights_ar_valid,
    output logic                   o_weights_ar_ready,
    output axi_ram_pkg::axi_r_t    o_weights_r,
    output logic                   o_weights_r_valid,
    input  logic                   i_weights_r_ready,
    output logic                   o_weights_rd,
    output axi_ram_pkg::ram_addr_t o_weights_raddr,
    input  axi_ram_pkg::axi_data_t i_weights_rdata,
    // Output write port
    input  axi_ram_pkg::axi_ax_t   i_out_aw,
    input  logic                   i_out_aw_valid,
    output logic                   o_out_aw_ready,
    input  axi_ram_pkg::axi_w_t    i_out_w,
    input  logic                   i_out_w_valid,
    output logic                   o_out_w_ready,
    output axi_ram_pkg::axi_b_t    o_out_b,
    output logic                   o_out_b_valid,
    input  logic                   i_out_b_ready,
    output logic                   o_out_we,
    output axi_ram_pkg::ram_addr_t o_out_waddr,
    output axi_ram_pkg::axi_data_t o_out_wdata,
    output axi_ram_pkg::axi_strb_t o_out_wstrb
);

    axi_read_to_ram #(
        .OPT_LOWPOWER (OPT_LOWPOWER)
    ) u_pixel_rd (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_ar       (i_pixel_ar),
        .i_ar_valid (i_pixel_ar_valid),
        .o_ar_ready (o_pixel_ar_ready),
        .o_r        (o_pixel_r),
        .o_r_valid  (o_pixel_r_valid),
        .i_r_ready  (i_pixel_r_ready),
        .o_rd       (o_pixel_rd),
        .o_raddr    (o_pixel_raddr),
        .i_rdata    (i_pixel_rdata)
    );

    axi_read_to_ram #(
        .OPT_LOWPOWER (OPT_LOWPOWER)
    ) u_weights_rd (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_ar       (i_weights_ar),
        .i_ar_valid (i_weights_ar_valid),
        .o_ar_ready (o_weights_ar_ready),
        .o_r        (o_weights_r),
        .o_r_valid  (o_weights_r_valid),
        .i_r_ready  (i_weights_r_ready),
        .o_rd       (o_weights_rd),
        .o_raddr    (o_weights_raddr),
        .i_rdata    (i_weights_rdata)
    );

    axi_write_to_ram #(
        .OPT_LOWPOWER (OPT_LOWPOWER)
    ) u_out_wr (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_aw       (i_out_aw),
        .i_aw_valid (i_out_aw_valid),
        .o_aw_ready (o_out_aw_ready),
        .i_w        (i_out_w),
        .i_w_valid  (i_out_w_valid),
        .o_w_ready  (o_out_w_ready),
        .o_b        (o_out_b),
        .o_b_valid  (o_out_b_valid),
        .i_b_ready  (i_out_b_ready),
        .o_we       (o_out_we),
        .o_waddr    (o_out_waddr),
        .o_wdata    (o_out_wdata),
        .o_wstrb    (o_out_wstrb)
    );

endmodule

// File: testbench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 2
) (
    output logic o_clk,
    output logic o_rst_n
);

    initial begin
        o_clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0) o_clk = ~o_clk;
        end
    end

    // Release on a rising edge so the DUT sees a clean reset edge count
    initial begin
        o_rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        o_rst_n <= 1'b1;
    end

endmodule

// File: testbench/axi_ram_bridge_tb.sv
`timescale 1ns/1ps

module axi_ram_bridge_tb;
    import axi_ram_pkg::*;

    localparam logic [31:0] SEED            = 32'h24a8_3354;
    localparam logic [1:0]  OKAY            = 2'b00;
    localparam bit          LOW_POWER       = 1'b1;
    localparam int          MAX_BEATS       = 16;
    localparam int          NUM_BURSTS      = 12;
    localparam int          STALL_BOUND     = 16;
    localparam int          WATCHDOG_CYCLES = NUM_BURSTS * MAX_BEATS * STALL_BOUND + 200;

    typedef struct packed {
        ram_addr_t addr;
        axi_data_t data;
        axi_strb_t strb;
    } ram_write_t;

    logic clk;
    logic rst_n;
    logic rst_prev = 1'b1;
    logic throttle = 1'b0;
    int   errors   = 0;
    int   checks   = 0;
    int   err_mark = 0;

    // Read ports indexed 0 for pixel and 1 for weights
    axi_ax_t   ar       [2] = '{default: '0};
    logic      ar_valid [2] = '{default: 1'b0};
    logic      ar_ready [2];
    axi_r_t    r_beat   [2];
    logic      r_valid  [2];
    logic      r_ready  [2] = '{default: 1'b0};
    logic      rd       [2];
    ram_addr_t raddr    [2];
    axi_data_t rdata    [2] = '{default: '0};
    axi_ax_t   ar_q     [2][$];
    axi_r_t    exp_r    [2][$];

    // Output write port
    axi_ax_t    aw       = '0;
    logic       aw_valid = 1'b0;
    logic       aw_ready;
    axi_w_t     w        = '0;
    logic       w_valid  = 1'b0;
    logic       w_ready;
    axi_b_t     b_beat;
    logic       b_valid;
    logic       b_ready  = 1'b0;
    logic       we;
    ram_addr_t  waddr;
    axi_data_t  wdata;
    axi_strb_t  wstrb;
    axi_ax_t    aw_q [$];
    axi_w_t     w_q [$];
    ram_write_t exp_wr [$];
    axi_b_t     exp_b [$];
    int         exp_b_writes [$];
    int         wr_total = 0;
    int         wr_seen  = 0;
    ram_write_t want_wr;
    axi_b_t     want_b;

    tb_clock_gen #(
        .PERIOD_NS    (4),
        .RESET_CYCLES (2)
    ) u_clock_gen (
        .o_clk   (clk),
        .o_rst_n (rst_n)
    );

    axi_ram_bridge_top #(
        .OPT_LOWPOWER (LOW_POWER)
    ) DUT (
        .clk                (clk),
        .i_rst_n            (rst_n),
        .i_pixel_ar         (ar[0]),
        .i_pixel_ar_valid   (ar_valid[0]),
        .o_pixel_ar_ready   (ar_ready[0]),
        .o_pixel_r          (r_beat[0]),
        .o_pixel_r_valid    (r_valid[0]),
        .i_pixel_r_ready    (r_ready[0]),
        .o_pixel_rd         (rd[0]),
        .o_pixel_raddr      (raddr[0]),
        .i_pixel_rdata      (rdata[0]),
        .i_weights_ar       (ar[1]),
        .i_weights_ar_valid (ar_valid[1]),
        .o_weights_ar_ready (ar_ready[1]),
        .o_weights_r        (r_beat[1]),
        .o_weights_r_valid  (r_valid[1]),
        .i_weights_r_ready  (r_ready[1]),
        .o_weights_rd       (rd[1]),
        .o_weights_raddr    (raddr[1]),
        .i_weights_rdata    (rdata[1]),
        .i_out_aw           (aw),
        .i_out_aw_valid     (aw_valid),
        .o_out_aw_ready     (aw_ready),
        .i_out_w            (w),
        .i_out_w_valid      (w_valid),
        .o_out_w_ready      (w_ready),
        .o_out_b            (b_beat),
        .o_out_b_valid      (b_valid),
        .i_out_b_ready      (b_ready),
        .o_out_we           (we),
        .o_out_waddr        (waddr),
        .o_out_wdata        (wdata),
        .o_out_wstrb        (wstrb)
    );

    // Read RAM contents differ per word address and port
    function automatic axi_data_t word_pattern(input ram_addr_t a, input int port);
        return {4'(port), a, 4'hc, ~a, 32'(a) * 32'h9e37_79b9, 4'(port), a};
    endfunction

    function automatic string port_name(input int port);
        return (port == 0) ? "pixel" : "weights";
    endfunction

    function automatic bit allow_valid();
        return !throttle || ($urandom_range(3) != 0);
    endfunction

    function automatic burst_t random_kind();
        case ($urandom_range(2))
            0:       return FIXED;
            1:       return INCR;
            default: return WRAP;
        endcase
    endfunction

    function automatic bit all_idle();
        return ar_q[0].size() == 0 && ar_q[1].size() == 0
            && exp_r[0].size() == 0 && exp_r[1].size() == 0
            && aw_q.size() == 0 && w_q.size() == 0
            && exp_wr.size() == 0 && exp_b.size() == 0;
    endfunction

    task automatic compare_field(input string name, input axi_data_t got, input axi_data_t want);
        checks++;
        assert (got === want) else begin
            errors++;
            $display("ERR %0t %s: got %0h, expected %0h", $time, name, got, want);
        end
    endtask

    task automatic queue_read(input int port, input burst_t kind);
        axi_ax_t   req;
        axi_r_t    beat;
        ram_addr_t word;
        int        len;
        req.id    = axi_id_t'($urandom);
        req.addr  = $urandom;
        req.len   = 8'($urandom_range(MAX_BEATS - 1));
        req.size  = 3'(WORD_LSB);
        req.burst = kind;
        len  = int'(req.len);
        word = req.addr[AXI_ADDR_WIDTH-1:WORD_LSB];
        // WRAP walks like INCR
        for (int i = 0; i <= len; i++) begin
            beat.id   = req.id;
            beat.data = word_pattern(word, port);
            beat.resp = OKAY;
            beat.last = (i == len);
            exp_r[port].push_back(beat);
            if (kind != FIXED) begin
                word = word + ram_addr_t'(1);
            end
        end
        ar_q[port].push_back(req);
    endtask

    task automatic queue_write(input burst_t kind);
        axi_ax_t    req;
        axi_w_t     beat;
        ram_write_t rec;
        axi_b_t     resp;
        int         len;
        req.id    = axi_id_t'($urandom);
        req.addr  = $urandom;
        req.len   = 8'($urandom_range(MAX_BEATS - 1));
        req.size  = 3'(WORD_LSB);
        req.burst = kind;
        len      = int'(req.len);
        rec.addr = req.addr[AXI_ADDR_WIDTH-1:WORD_LSB];
        for (int i = 0; i <= len; i++) begin
            beat.data = {$urandom, $urandom, $urandom, $urandom};
            beat.strb = axi_strb_t'($urandom);
            beat.last = (i == len);
            w_q.push_back(beat);
            rec.data = beat.data;
            rec.strb = beat.strb;
            exp_wr.push_back(rec);
            if (kind != FIXED) begin
                rec.addr = rec.addr + ram_addr_t'(1);
            end
        end
        wr_total  = wr_total + len + 1;
        resp.id   = req.id;
        resp.resp = OKAY;
        exp_b.push_back(resp);
        exp_b_writes.push_back(wr_total);
        aw_q.push_back(req);
    endtask

    task automatic wait_idle();
        do begin
            @(posedge clk);
        end while (!all_idle());
        repeat (4) @(posedge clk);
    endtask

    task automatic report_test(input string name, input int mark);
        if (errors == mark) begin
            $display("test %s: pass", name);
        end else begin
            $display("test %s: fail, %0d errors", name, errors - mark);
        end
    endtask

    // Checked while reset is held and in the first cycle after release
    always @(posedge clk) begin
        if (!rst_prev) begin
            compare_field("ready, valid and RAM strobe outputs",
                          axi_data_t'({ar_ready[0], ar_ready[1], r_valid[0], r_valid[1],
                                       rd[0], rd[1], aw_ready, w_ready, b_valid, we}),
                          '0);
        end
        rst_prev <= rst_n;
    end

    for (genvar p = 0; p < 2; p++) begin : g_read
        axi_r_t want;
        int     issued = 0;
        int     taken  = 0;

        // Read RAM returns data one cycle after the strobe
        always @(posedge clk) begin
            if (rd[p]) begin
                rdata[p] <= word_pattern(raddr[p], p);
            end
        end

        always @(posedge clk) begin
            if (!rst_n) begin
                ar_valid[p] <= 1'b0;
                r_ready[p]  <= 1'b0;
            end else begin
                if (!ar_valid[p] || ar_ready[p]) begin
                    if (ar_q[p].size() != 0 && allow_valid()) begin
                        ar[p]       <= ar_q[p].pop_front();
                        ar_valid[p] <= 1'b1;
                    end else begin
                        ar_valid[p] <= 1'b0;
                    end
                end
                r_ready[p] <= !throttle || ($urandom_range(1) == 1);
            end
        end

        always @(posedge clk) begin
            if (rst_n) begin
                if (rd[p]) begin
                    checks++;
                    assert (issued - taken < 2) else begin
                        errors++;
                        $display("port %s issued a RAM read at %0t with %0d beats already pending",
                                 port_name(p), $time, issued - taken);
                    end
                    issued++;
                end
                if (r_valid[p] && r_ready[p]) begin
                    taken++;
                    if (exp_r[p].size() == 0) begin
                        errors++;
                        $display("port %s returned an R beat at %0t that was never requested",
                                 port_name(p), $time);
                    end else begin
                        want = exp_r[p].pop_front();
                        compare_field({"o_", port_name(p), "_r.id"},
                                      axi_data_t'(r_beat[p].id), axi_data_t'(want.id));
                        compare_field({"o_", port_name(p), "_r.data"}, r_beat[p].data, want.data);
                        compare_field({"o_", port_name(p), "_r.resp"},
                                      axi_data_t'(r_beat[p].resp), axi_data_t'(want.resp));
                        compare_field({"o_", port_name(p), "_r.last"},
                                      axi_data_t'(r_beat[p].last), axi_data_t'(want.last));
                    end
                end
            end
        end

        assert property (@(posedge clk) disable iff (!rst_n)
            (r_valid[p] && !r_ready[p]) |=> (r_valid[p] && $stable(r_beat[p])))
        else begin
            errors++;
            $display("port %s dropped or changed a stalled R beat at %0t", port_name(p), $time);
        end

        // Low-power mode parks the read address at zero between reads
        assert property (@(posedge clk) disable iff (!rst_n)
            (LOW_POWER && !rd[p]) |-> (raddr[p] == '0))
        else begin
            errors++;
            $display("port %s drove a RAM read address with the read strobe low at %0t",
                     port_name(p), $time);
        end
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            aw_valid <= 1'b0;
            w_valid  <= 1'b0;
            b_ready  <= 1'b0;
        end else begin
            if (!aw_valid || aw_ready) begin
                if (aw_q.size() != 0 && allow_valid()) begin
                    aw       <= aw_q.pop_front();
                    aw_valid <= 1'b1;
                end else begin
                    aw_valid <= 1'b0;
                end
            end
            if (!w_valid || w_ready) begin
                if (w_q.size() != 0 && allow_valid()) begin
                    w       <= w_q.pop_front();
                    w_valid <= 1'b1;
                end else begin
                    w_valid <= 1'b0;
                end
            end
            b_ready <= !throttle || ($urandom_range(1) == 1);
        end
    end

    // Write RAM side and B channel
    always @(posedge clk) begin
        if (rst_n) begin
            if (b_valid && b_ready) begin
                if (exp_b.size() == 0) begin
                    errors++;
                    $display("output port sent a write response at %0t with no burst open", $time);
                end else begin
                    want_b = exp_b.pop_front();
                    compare_field("o_out_b.id", axi_data_t'(b_beat.id), axi_data_t'(want_b.id));
                    compare_field("o_out_b.resp", axi_data_t'(b_beat.resp),
                                  axi_data_t'(want_b.resp));
                    compare_field("RAM writes before o_out_b", axi_data_t'(wr_seen),
                                  axi_data_t'(exp_b_writes.pop_front()));
                end
            end
            if (we) begin
                wr_seen++;
                if (exp_wr.size() == 0) begin
                    errors++;
                    $display("output port wrote the RAM at %0t with no W beat pending", $time);
                end else begin
                    want_wr = exp_wr.pop_front();
                    compare_field("o_out_waddr", axi_data_t'(waddr), axi_data_t'(want_wr.addr));
                    compare_field("o_out_wdata", wdata, want_wr.data);
                    compare_field("o_out_wstrb", axi_data_t'(wstrb), axi_data_t'(want_wr.strb));
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        (b_valid && !b_ready) |=> (b_valid && $stable(b_beat)))
    else begin
        errors++;
        $display("output port dropped or changed a stalled write response at %0t", $time);
    end

    // Low-power mode parks address, data and strobe at zero between writes
    assert property (@(posedge clk) disable iff (!rst_n)
        (LOW_POWER && !we) |-> (waddr == '0 && wdata == '0 && wstrb == '0))
    else begin
        errors++;
        $display("output port drove the RAM write bus with the write enable low at %0t", $time);
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        wait (rst_n === 1'b1);
        repeat (3) @(posedge clk);
        report_test("reset", 0);

        err_mark = errors;
        queue_read(0, INCR);
        queue_read(1, INCR);
        wait_idle();
        report_test("incr read", err_mark);

        err_mark = errors;
        queue_read(0, FIXED);
        queue_read(1, FIXED);
        wait_idle();
        report_test("fixed read", err_mark);

        err_mark = errors;
        queue_write(INCR);
        queue_write(FIXED);
        wait_idle();
        report_test("incr and fixed write", err_mark);

        // Two bursts per port back to back under random valid and ready
        err_mark = errors;
        throttle = 1'b1;
        for (int n = 0; n < 2; n++) begin
            queue_read(0, random_kind());
            queue_read(1, random_kind());
            queue_write(random_kind());
        end
        wait_idle();
        throttle = 1'b0;
        report_test("back-pressure", err_mark);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: all.f
design/axi_ram_pkg.sv
design/axi_skid_buffer.sv
design/burst_addr_gen.sv
design/axi_read_to_ram.sv
design/axi_write_to_ram.sv
design/axi_ram_bridge_top.sv
testbench/tb_clock_gen.sv
testbench/axi_ram_bridge_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= axi_ram_bridge_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
